// File: address_unit.sv
/*
 * address unit
 * program counter and memory address register. mar drives the memory
 * address and loads from pc or from read data for direct operands
 */
`default_nettype none

module address_unit import cpu_pkg::*; #(
    parameter addr_t reset_pc = '0  // first opcode address
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire ctrl_t ctrl,
    input  wire data_t rd_data,   // operand byte for direct addressing
    output addr_t      mem_addr
);

    addr_t pc;
    addr_t mar;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= reset_pc;
        end else if (ctrl.pc_inc) begin
            pc <= pc + addr_t'(1);  // wraps at 0xff
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            // pc for opcode and operand fetch, read data for the data address
            mar <= (ctrl.mar_src == MAR_FROM_MEM) ? addr_t'(rd_data) : pc;
        end
    end

    assign mem_addr = mar;  // memory always reads at mar

    // sequencer never steps pc in a mar load cycle, so mar sees a stable pc
    pc_mar_apart: assert property (
        @(posedge clk) disable iff (!reset)
        !(ctrl.pc_inc && ctrl.mar_load)
    ) else $error("pc_inc and mar_load high together");

endmodule

`default_nettype wire

// File: cpu_pkg.sv
/*
 * cpu package
 * shared widths, the load opcodes and the control word that the
 * sequencer hands to the datapath of the accumulator cpu
 */
`default_nettype none

package cpu_pkg;

    // one byte on the read bus and in every data register
    typedef logic [7:0] data_t;

    // byte address held in pc and mar
    typedef logic [7:0] addr_t;

    // load group opcodes
    // bit 0 picks direct addressing and bit 1 picks register b
    typedef enum logic [7:0] {
        LDA_IMM = 8'h10,  // a <= next byte
        LDA_DIR = 8'h11,  // a <= mem[next byte]
        LDB_IMM = 8'h12,  // b <= next byte
        LDB_DIR = 8'h13   // b <= mem[next byte]
    } opcode_e;

    // control word, one strobe set per sequencer state
    // all fields are single cycle level strobes
    typedef struct packed {
        logic ir_load;   // capture opcode from read data
        logic mar_load;  // mar takes the selected source
        logic mar_src;   // 0 pc, 1 memory read data
        logic pc_inc;    // pc + 1
        logic a_load;    // a from read data
        logic b_load;    // b from read data
    } ctrl_t;

    // width of the control word, handy when probing it as a vector
    localparam int CTRL_W = $bits(ctrl_t);

    // mar source select values
    localparam logic MAR_FROM_PC  = 1'b0;
    localparam logic MAR_FROM_MEM = 1'b1;

endpackage

`default_nettype wire

// File: data_registers.sv
/*
 * data registers
 * instruction register and the a and b accumulators, all loaded from
 * the memory read bus on their strobes and held otherwise
 */
`default_nettype none

module data_registers import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire ctrl_t ctrl,
    input  wire data_t rd_data,
    output data_t      ir,      // opcode for the sequencer
    output data_t      reg_a,
    output data_t      reg_b
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= '0;
        end else if (ctrl.ir_load) begin
            ir <= rd_data;  // end of fetch_2
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            reg_a <= '0;
            reg_b <= '0;
        end else begin
            if (ctrl.a_load)
                reg_a <= rd_data;  // last execute cycle
            if (ctrl.b_load)
                reg_b <= rd_data;
        end
    end

    // the read bus carries one byte per cycle, so only one register may take it
    one_rd_sink: assert property (
        @(posedge clk) disable iff (!reset)
        $onehot0({ctrl.ir_load, ctrl.a_load, ctrl.b_load})
    ) else $error("more than one register loading rd_data");

endmodule

`default_nettype wire

// File: load_store_control.sv
/*
 * load/store control unit
 * moore sequencer for fetch, decode and execute of the four load
 * instructions. one state per cycle, each state drives one control word
 * unknown opcodes fall straight back to fetch and act as a one byte nop
 */
`default_nettype none

module load_store_control import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire data_t ir,    // opcode captured in fetch_2
    output ctrl_t      ctrl   // strobes to address unit and data registers
);

    typedef enum logic [3:0] {
        fetch_0,  // mar <= pc
        fetch_1,  // pc++ while memory reads opcode
        fetch_2,  // ir <= rd_data
        decode,
        imm_0,    // mar <= pc (operand address)
        imm_1,    // pc++
        imm_2,    // a/b <= operand
        dir_0,    // mar <= pc
        dir_1,    // pc++
        dir_2,    // mar <= operand
        dir_3     // a/b <= mem[operand]
    } state_e;

    state_e state, next_state;
    logic   dest_b;  // destination of the running load, set at decode

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state  <= fetch_0;
            dest_b <= 1'b0;
        end else begin
            state <= next_state;
            if (state == decode)
                dest_b <= ir[1];  // 0x12/0x13 target b
        end
    end

    // transition function
    always_comb begin
        next_state = state;
        case (state)
            fetch_0: next_state = fetch_1;
            fetch_1: next_state = fetch_2;
            fetch_2: next_state = decode;
            decode: begin
                case (ir)
                    LDA_IMM, LDB_IMM: next_state = imm_0;
                    LDA_DIR, LDB_DIR: next_state = dir_0;
                    default:          next_state = fetch_0;  // skip unknown opcode
                endcase
            end
            imm_0:   next_state = imm_1;
            imm_1:   next_state = imm_2;
            imm_2:   next_state = fetch_0;
            dir_0:   next_state = dir_1;
            dir_1:   next_state = dir_2;
            dir_2:   next_state = dir_3;
            dir_3:   next_state = fetch_0;
            default: next_state = fetch_0;
        endcase
    end

    // output decode, current state only
    always_comb begin
        ctrl = '0;
        case (state)
            fetch_0, imm_0, dir_0: begin
                ctrl.mar_load = 1'b1;
                ctrl.mar_src  = MAR_FROM_PC;
            end
            fetch_1, imm_1, dir_1: ctrl.pc_inc = 1'b1;  // memory busy, step pc
            fetch_2:               ctrl.ir_load = 1'b1;
            dir_2: begin
                // operand byte on rd_data becomes the data address
                ctrl.mar_load = 1'b1;
                ctrl.mar_src  = MAR_FROM_MEM;
            end
            imm_2, dir_3: begin
                ctrl.a_load = !dest_b;
                ctrl.b_load = dest_b;
            end
            default: ;  // decode holds everything
        endcase
    end

    // only one destination register per instruction
    a_b_exclusive: assert property (
        @(posedge clk) disable iff (!reset)
        !(ctrl.a_load && ctrl.b_load)
    ) else $error("a_load and b_load high together");

    // decode is a single cycle, whatever ir holds
    decode_one_cycle: assert property (
        @(posedge clk) disable iff (!reset)
        (state == decode) |=> (state != decode)
    ) else $error("decode lasted more than one cycle");

endmodule

`default_nettype wire

// File: load_store_cpu.f
cpu_pkg.sv
load_store_control.sv
address_unit.sv
data_registers.sv
load_store_cpu.sv
tb_program_memory.sv
tb_load_store_cpu.sv

// File: load_store_cpu.sv
/*
 * load/store cpu top
 * 8-bit accumulator cpu front end. connects the sequencer, the address
 * unit and the data registers to an external read-only memory
 */
`default_nettype none

module load_store_cpu import cpu_pkg::*; #(
    parameter addr_t reset_pc = '0  // pc after reset
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire data_t rd_data,   // memory read data, one cycle after mem_addr
    output addr_t      mem_addr,
    output data_t      reg_a,
    output data_t      reg_b
);

    ctrl_t ctrl;  // control word from the sequencer
    data_t ir;    // current opcode back to the sequencer

    load_store_control control_i (
        .clk   (clk),
        .reset (reset),
        .ir    (ir),
        .ctrl  (ctrl)
    );

    // pc and mar
    address_unit #(
        .reset_pc (reset_pc)
    ) address_i (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .rd_data  (rd_data),
        .mem_addr (mem_addr)
    );

    // ir, a and b
    data_registers data_i (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .rd_data (rd_data),
        .ir      (ir),
        .reg_a   (reg_a),
        .reg_b   (reg_b)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the load/store cpu testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f load_store_cpu.f --top-module tb_load_store_cpu -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation did not complete"
    exit 1
fi

if echo "$output" | grep -q "No errors"; then
    exit 0
fi
exit 1

// File: tb_load_store_cpu.sv
/*
 * load/store cpu testbench
 * builds a mixed program of loads and unknown opcodes over random data,
 * runs it from reset and checks mem_addr, reg_a and reg_b on the cycles
 * given by the fetch, decode and execute timing
 */
`default_nettype none

module tb_load_store_cpu import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_instr  = 10;
    localparam int wait_limit = 16;  // cycles per wait

    logic  clk;
    logic  reset;
    data_t rd_data;
    addr_t mem_addr;
    data_t reg_a;
    data_t reg_b;

    data_t       image [256];   // expected memory contents
    data_t       ops [num_instr] = '{LDA_IMM, LDB_DIR, 8'h00, LDA_DIR, LDB_IMM,
                                     LDA_DIR, LDB_IMM, 8'h14, LDA_IMM, LDB_DIR};
    logic [15:0] lfsr_state;
    int          cyc;               // rising edges since reset release
    int          reset_cycles = 0;
    int          errors = 0;
    int          timeouts = 0;
    data_t       exp_a;
    data_t       exp_b;

    load_store_cpu load_store_cpu_i (
        .clk      (clk),
        .reset    (reset),
        .rd_data  (rd_data),
        .mem_addr (mem_addr),
        .reg_a    (reg_a),
        .reg_b    (reg_b)
    );

    tb_program_memory memory_i (
        .clk     (clk),
        .addr    (mem_addr),
        .rd_data (rd_data)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk or negedge reset) begin
        if (!reset)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    always @(posedge clk) begin
        if (!reset)
            reset_cycles <= reset_cycles + 1;
    end

    // first edge only applies reset, so look from the second one on
    reset_clears: assert property (
        @(posedge clk) (!reset && reset_cycles > 0) |-> ({mem_addr, reg_a, reg_b} == 24'h0)
    ) else begin
        errors++;
        $display("error reset_clear: expected %h, actual %h", 24'h0, {mem_addr, reg_a, reg_b});
    end

    // one destination per load
    one_register_per_step: assert property (
        @(posedge clk) disable iff (!reset)
        !((reg_a != $past(reg_a)) && (reg_b != $past(reg_b)))
    ) else begin
        errors++;
        $display("reg_a and reg_b changed in the same cycle");
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output data_t bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[6:0], lfsr_state[0]};  // newest bit shifted in at the lsb
        end
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        assert (actual == expected) else begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // step falling edges until the cycle count reaches target
    task automatic wait_cycle(input int target);
        int waited;
        waited = 0;
        while (cyc < target) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                timeouts++;
                $display("timeout while waiting for cycle %0d", target);
                finish_run();
            end
        end
    endtask

    // one instruction from its fetch_0 cycle; length 4 unknown, 7 immediate, 8 direct
    task automatic run_instr(input addr_t pc, input int start, output int length);
        data_t op;
        data_t arg;
        data_t value;
        logic  known;
        logic  direct;
        logic  to_b;
        op     = image[pc];
        arg    = image[pc + 8'd1];
        known  = (op == LDA_IMM) || (op == LDA_DIR) || (op == LDB_IMM) || (op == LDB_DIR);
        direct = (op == LDA_DIR) || (op == LDB_DIR);
        to_b   = (op == LDB_IMM) || (op == LDB_DIR);
        length = !known ? 4 : (direct ? 8 : 7);
        value  = direct ? image[arg] : arg;
        wait_cycle(start + 1);
        check_value("fetch_addr", pc, mem_addr);  // mar loaded in fetch_0
        if (known) begin
            wait_cycle(start + 5);
            check_value("operand_addr", pc + 8'd1, mem_addr);
        end
        if (direct) begin
            wait_cycle(start + 7);
            check_value("data_addr", arg, mem_addr);  // operand became the address
        end
        wait_cycle(start + length - 1);
        check_value("reg_a_hold", exp_a, reg_a);  // nothing moves before the last cycle
        check_value("reg_b_hold", exp_b, reg_b);
        if (known && !to_b)
            exp_a = value;
        if (known && to_b)
            exp_b = value;
        wait_cycle(start + length);
        check_value("reg_a", exp_a, reg_a);
        check_value("reg_b", exp_b, reg_b);
    endtask

    initial begin
        addr_t pc;
        data_t bits;
        int    start;
        int    length;
        reset      = 1'b0;
        exp_a      = '0;
        exp_b      = '0;
        lfsr_state = 16'd30;
        // data area gets random bytes, code filler stays above the opcodes
        for (int a = 0; a < 256; a++) begin
            if (a >= 128) begin
                take_bits(8, bits);
                image[a] = bits;
            end else begin
                image[a] = 8'(a) ^ 8'hc3;
            end
        end
        pc = '0;
        for (int i = 0; i < num_instr; i++) begin
            image[pc] = ops[i];
            if (ops[i] == LDA_DIR || ops[i] == LDB_DIR) begin
                take_bits(7, bits);
                image[pc + 8'd1] = bits | 8'h80;  // pointer into the data area
                pc = pc + 8'd2;
            end else if (ops[i] == LDA_IMM || ops[i] == LDB_IMM) begin
                take_bits(8, bits);
                image[pc + 8'd1] = bits;
                pc = pc + 8'd2;
            end else begin
                pc = pc + 8'd1;  // unknown opcode, single byte
            end
        end
        for (int a = 0; a < 256; a++)
            memory_i.preload(8'(a), image[a]);

        repeat (16) @(negedge clk);
        reset = 1'b1;
        start = 0;
        pc    = '0;
        for (int i = 0; i < num_instr; i++) begin
            run_instr(pc, start, length);
            start = start + length;
            pc    = pc + ((length == 4) ? 8'd1 : 8'd2);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: tb_program_memory.sv
/*
 * program memory model
 * 256 byte read-only memory for the cpu testbench. the address set at a
 * rising edge is read and driven on rd_data from the next falling edge
 */
`default_nettype none

module tb_program_memory import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire addr_t addr,     // mar of the cpu
    output data_t      rd_data
);
    timeunit 1ns;
    timeprecision 100ps;

    data_t mem [256];

    initial begin
        rd_data = '0;
    end

    // mar only moves on rising edges, so it is settled here
    always @(negedge clk) begin
        rd_data <= mem[addr];  // held until the next falling edge
    end

    // image load before reset is released
    task automatic preload(input addr_t a, input data_t d);
        mem[a] = d;
    endtask

endmodule

`default_nettype wire
